// ==== sources.f ====
design/periph_pkg.sv
design/apb_splitter.sv
design/riscv_timer.sv
design/uart_regs.sv
design/uart_fifo.sv
design/uart_tx.sv
design/periph_subsys.sv
verif/periph_subsys_chk.sv
verif/tb_periph_subsys.sv

// ==== Makefile ====
# Verilator flow for the peripheral subsystem

VERILATOR ?= verilator
TOP       ?= tb_periph_subsys
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_periph_subsys.sv ====
// testbench for the peripheral subsystem: APB traffic, timer and UART line checks
`timescale 1ns/1ps

module tb_periph_subsys;
	import periph_pkg::*;

	localparam int        CLK_PERIOD = 4;
	localparam int        BIT_CLKS   = 8;
	localparam int        N_CHARS    = 6;
	localparam int        FILL_MAX   = 12;
	localparam int        WAIT_CLKS  = 100;
	localparam int        IRQ_WAIT   = 6 * CLK_MHZ + 2;
	localparam int        POLL_MAX   = 400;
	// ten-bit frames and timer waits doubled for bus overhead
	localparam int        WATCHDOG_CLKS = 2 * ((N_CHARS + FILL_MAX) * 10 * BIT_CLKS
		+ 4 * WAIT_CLKS + IRQ_WAIT) + 2000;
	localparam apb_addr_t UART_BASE  = 16'h4000;

	logic       clk;
	logic       rst_n;
	logic       psel;
	logic       penable;
	logic       pwrite;
	apb_addr_t  paddr;
	word_t      pwdata;
	word_t      prdata;
	logic       pslverr;
	logic       dbg_halt;
	logic       timer_irq;
	logic       uart_irq;
	logic       uart_tx;

	int         errors = 0;
	int         checks = 0;
	int         cycle = 0;
	int         read_cycle;
	logic [7:0] lfsr_state = 8'd9;
	byte_t      exp_q[$];

	periph_subsys u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
	endfunction

	function automatic byte_t rand_byte();
		byte_t b;
		int    i;
		b = '0;
		for (i = 0; i < 8; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			b[i] = lfsr_state[0];
		end
		return b;
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// ------------------------------
	// APB master
	// ------------------------------
	task automatic apb_write(input apb_addr_t addr, input word_t data, input logic exp_err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_value("pslverr", word_t'(pslverr), word_t'(exp_err));
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, input logic exp_err, output word_t data);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		read_cycle = cycle;
		check_value("pslverr", word_t'(pslverr), word_t'(exp_err));
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_expect(input apb_addr_t addr, input word_t exp, input string name);
		word_t d;
		apb_read(addr, 1'b0, d);
		check_value(name, d, exp);
	endtask

	// poll STATUS until the masked bits match
	task automatic poll_status(input word_t mask, input word_t value, input string what);
		word_t st;
		int    n;
		n = 0;
		apb_read(UART_BASE | UART_STATUS, 1'b0, st);
		while ((st & mask) != value && n < POLL_MAX) begin
			apb_read(UART_BASE | UART_STATUS, 1'b0, st);
			n++;
		end
		checks++;
		assert ((st & mask) == value) else begin
			errors++;
			$display("%s after %0d status polls", what, POLL_MAX);
		end
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic check_reset_and_decode();
		word_t d;
		@(negedge clk);
		check_value("timer_irq", word_t'(timer_irq), 32'd0);
		check_value("uart_irq", word_t'(uart_irq), 32'd0);
		check_value("uart_tx", word_t'(uart_tx), 32'd1);
		check_value("tx_req", word_t'(u_dut.tx_req), 32'd0);
		check_value("tx_ack", word_t'(u_dut.tx_ack), 32'd0);
		read_expect(TIMER_MTIME, 32'd0, "mtime");
		read_expect(TIMER_MTIMECMP, 32'hffff_ffff, "mtimecmp");
		read_expect(TIMER_MTIMECMPH, 32'hffff_ffff, "mtimecmph");
		read_expect(UART_BASE | UART_CLKDIV, 32'd15, "clkdiv");
		// only the empty flag
		read_expect(UART_BASE | UART_STATUS, 32'h2, "status");
		// regions 2 and 3 are unmapped
		apb_read(16'h8000, 1'b1, d);
		check_value("prdata", d, 32'd0);
		apb_read(16'hc008, 1'b1, d);
		check_value("prdata", d, 32'd0);
		apb_write(16'hc004, 32'h55, 1'b1);
	endtask

	task automatic count_timer();
		word_t m0;
		word_t m1;
		int    c0;
		int    ticks;
		int    d;
		apb_write(TIMER_CTRL, 32'd1, 1'b0);
		apb_read(TIMER_MTIME, 1'b0, m0);
		c0 = read_cycle;
		repeat (WAIT_CLKS) @(posedge clk);
		apb_read(TIMER_MTIME, 1'b0, m1);
		ticks = (read_cycle - c0) / CLK_MHZ;
		d = int'(m1 - m0);
		checks++;
		assert (d >= ticks - 1 && d <= ticks + 1) else begin
			errors++;
			$display("FAILED mtime: advanced 0x%h, expected 0x%h +/- 1", d, ticks);
		end
		apb_write(TIMER_CTRL, 32'd0, 1'b0);
		apb_write(TIMER_MTIME, 32'h1234_5678, 1'b0);
		apb_write(TIMER_MTIMEH, 32'h0000_00ab, 1'b0);
		read_expect(TIMER_MTIME, 32'h1234_5678, "mtime");
		read_expect(TIMER_MTIMEH, 32'h0000_00ab, "mtimeh");
		apb_write(TIMER_MTIME, 32'd0, 1'b0);
		apb_write(TIMER_MTIMEH, 32'd0, 1'b0);
	endtask

	task automatic hold_in_debug();
		word_t a;
		word_t c;
		apb_write(TIMER_CTRL, 32'd1, 1'b0);
		@(posedge clk);
		dbg_halt <= 1'b1;
		apb_read(TIMER_MTIME, 1'b0, a);
		repeat (WAIT_CLKS) @(posedge clk);
		read_expect(TIMER_MTIME, a, "mtime");
		@(posedge clk);
		dbg_halt <= 1'b0;
		repeat (WAIT_CLKS) @(posedge clk);
		apb_read(TIMER_MTIME, 1'b0, c);
		checks++;
		assert (c > a) else begin
			errors++;
			$display("FAILED mtime: 0x%h after release, expected above 0x%h", c, a);
		end
	endtask

	task automatic fire_timer_irq();
		word_t m;
		int    n;
		apb_read(TIMER_MTIME, 1'b0, m);
		apb_write(TIMER_MTIMECMP, m + 32'd5, 1'b0);
		apb_write(TIMER_MTIMECMPH, 32'd0, 1'b0);
		@(negedge clk);
		check_value("timer_irq", word_t'(timer_irq), 32'd0);
		n = 0;
		while (timer_irq !== 1'b1 && n < IRQ_WAIT) begin
			@(negedge clk);
			n++;
		end
		checks++;
		assert (timer_irq === 1'b1) else begin
			errors++;
			$display("timer_irq did not rise within %0d clocks of the compare write", IRQ_WAIT);
		end
		apb_write(TIMER_MTIMECMP, 32'hffff_ffff, 1'b0);
		apb_write(TIMER_MTIMECMPH, 32'hffff_ffff, 1'b0);
		@(negedge clk);
		check_value("timer_irq", word_t'(timer_irq), 32'd0);
	endtask

	task automatic send_characters();
		byte_t b;
		apb_write(UART_BASE | UART_CLKDIV, BIT_CLKS - 1, 1'b0);
		read_expect(UART_BASE | UART_CLKDIV, BIT_CLKS - 1, "clkdiv");
		repeat (N_CHARS) begin
			poll_status(32'h1, 32'h0, "transmit FIFO stayed full");
			b = rand_byte();
			exp_q.push_back(b);
			apb_write(UART_BASE | UART_TXDATA, word_t'(b), 1'b0);
		end
		poll_status(32'h6, 32'h2, "UART did not go idle");
		check_value("pending characters", word_t'(exp_q.size()), 32'd0);
	endtask

	task automatic overflow_fifo();
		word_t st;
		byte_t b;
		int    n;
		apb_write(UART_BASE | UART_CTRL, 32'd1, 1'b0);
		@(negedge clk);
		check_value("uart_irq", word_t'(uart_irq), 32'd1);
		n = 0;
		apb_read(UART_BASE | UART_STATUS, 1'b0, st);
		while (!st[0] && n < FILL_MAX) begin
			b = rand_byte();
			exp_q.push_back(b);
			apb_write(UART_BASE | UART_TXDATA, word_t'(b), 1'b0);
			apb_read(UART_BASE | UART_STATUS, 1'b0, st);
			n++;
		end
		check_value("status full", word_t'(st[0]), 32'd1);
		@(negedge clk);
		check_value("uart_irq", word_t'(uart_irq), 32'd0);
		// rejected and never queued
		apb_write(UART_BASE | UART_TXDATA, word_t'(rand_byte()), 1'b1);
		poll_status(32'h6, 32'h2, "UART did not go idle");
		@(negedge clk);
		check_value("uart_irq", word_t'(uart_irq), 32'd1);
		check_value("pending characters", word_t'(exp_q.size()), 32'd0);
	endtask

	// ------------------------------
	// line receiver
	// ------------------------------
	initial begin : line_monitor
		byte_t rx;
		int    i;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge clk);
			if (uart_tx === 1'b0) begin
				// centre of the start bit
				repeat (BIT_CLKS / 2) @(negedge clk);
				check_value("uart_tx start bit", word_t'(uart_tx), 32'd0);
				for (i = 0; i < 8; i++) begin
					repeat (BIT_CLKS) @(negedge clk);
					rx[i] = uart_tx;
				end
				repeat (BIT_CLKS) @(negedge clk);
				check_value("uart_tx stop bit", word_t'(uart_tx), 32'd1);
				checks++;
				assert (exp_q.size() > 0) else begin
					errors++;
					$display("character 0x%h arrived with nothing queued", rx);
				end
				if (exp_q.size() > 0)
					check_value("uart_tx byte", word_t'(rx), word_t'(exp_q.pop_front()));
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CLKS) @(posedge clk);
		$display("timeout: run exceeded %0d clocks", WATCHDOG_CLKS);
		$display("checks: %0d, errors: %0d", checks, errors + 1);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		rst_n    = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		dbg_halt = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		check_reset_and_decode();
		count_timer();
		hold_in_debug();
		fire_timer_irq();
		send_characters();
		overflow_fifo();
		errors = errors + int'(u_dut.u_chk.fail_count);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== verif/periph_subsys_chk.sv ====
// handshake and line idle assertions for the peripheral subsystem
`timescale 1ns/1ps

module periph_subsys_chk (
	input logic              clk,
	input logic              rst_n,
	input logic              tx_req,
	input logic              tx_ack,
	input periph_pkg::byte_t tx_data,
	input logic              busy,
	input logic              uart_tx
);
	int unsigned fail_count = 0;

	// ------------------------------
	// four-phase handshake
	// ------------------------------
	req_held: assert property (@(posedge clk) disable iff (!rst_n)
		tx_req && !tx_ack |=> tx_req)
		else begin
			$error("tx_req dropped before tx_ack");
			fail_count++;
		end

	ack_held: assert property (@(posedge clk) disable iff (!rst_n)
		tx_ack && tx_req |=> tx_ack)
		else begin
			$error("tx_ack dropped while tx_req still high");
			fail_count++;
		end

	data_stable: assert property (@(posedge clk) disable iff (!rst_n)
		tx_req |=> !tx_req || $stable(tx_data))
		else begin
			$error("tx_data changed under tx_req");
			fail_count++;
		end

	// line idles high
	line_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> uart_tx)
		else begin
			$error("uart_tx low while serializer idle");
			fail_count++;
		end

endmodule

bind periph_subsys periph_subsys_chk u_chk (
	.clk     (clk),
	.rst_n   (rst_n),
	.tx_req  (tx_req),
	.tx_ack  (tx_ack),
	.tx_data (tx_data),
	.busy    (busy),
	.uart_tx (uart_tx)
);

// ==== design/periph_subsys.sv ====
// peripheral subsystem top: APB splitter, machine timer and transmit UART
`timescale 1ns/1ps

module periph_subsys (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  periph_pkg::apb_addr_t paddr,
	input  periph_pkg::word_t     pwdata,
	output periph_pkg::word_t     prdata,
	output logic                  pslverr,
	input  logic                  dbg_halt,
	output logic                  timer_irq,
	output logic                  uart_irq,
	output logic                  uart_tx
);
	import periph_pkg::*;

	logic    timer_psel;
	logic    uart_psel;
	word_t   timer_prdata;
	logic    timer_pslverr;
	word_t   uart_prdata;
	logic    uart_pslverr;

	// uart chain
	logic    push;
	byte_t   push_data;
	logic    full;
	logic    empty;
	logic    busy;
	clkdiv_t clkdiv;
	logic    tx_req;
	byte_t   tx_data;
	logic    tx_ack;

	apb_splitter u_splitter (
		.psel          (psel),
		.paddr         (paddr),
		.timer_psel    (timer_psel),
		.uart_psel     (uart_psel),
		.timer_prdata  (timer_prdata),
		.timer_pslverr (timer_pslverr),
		.uart_prdata   (uart_prdata),
		.uart_pslverr  (uart_pslverr),
		.prdata        (prdata),
		.pslverr       (pslverr)
	);

	riscv_timer u_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (timer_psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (timer_prdata),
		.pslverr   (timer_pslverr),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	uart_regs u_uart_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (uart_psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (uart_prdata),
		.pslverr   (uart_pslverr),
		.push      (push),
		.push_data (push_data),
		.full      (full),
		.empty     (empty),
		.busy      (busy),
		.clkdiv    (clkdiv),
		.uart_irq  (uart_irq)
	);

	uart_fifo u_uart_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.push_data (push_data),
		.full      (full),
		.empty     (empty),
		.tx_req    (tx_req),
		.tx_data   (tx_data),
		.tx_ack    (tx_ack)
	);

	uart_tx u_uart_tx (
		.clk     (clk),
		.rst_n   (rst_n),
		.tx_req  (tx_req),
		.tx_data (tx_data),
		.tx_ack  (tx_ack),
		.clkdiv  (clkdiv),
		.busy    (busy),
		.uart_tx (uart_tx)
	);

endmodule

// ==== design/uart_tx.sv ====
// UART transmitter: 8N1 serializer with a programmable bit period
`timescale 1ns/1ps

module uart_tx (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                tx_req,
	input  periph_pkg::byte_t   tx_data,
	output logic                tx_ack,
	input  periph_pkg::clkdiv_t clkdiv,
	output logic                busy,
	output logic                uart_tx
);
	import periph_pkg::*;

	tx_state_t state;
	clkdiv_t   bit_ctr;
	logic [2:0] bit_idx;
	byte_t     shreg;

	assign busy = (state != TX_IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= TX_IDLE;
			tx_ack  <= 1'b0;
			bit_ctr <= '0;
			bit_idx <= '0;
			shreg   <= '0;
			uart_tx <= 1'b1;
		end else begin
			// release ack once the fifo has withdrawn its request
			if (tx_ack && !tx_req)
				tx_ack <= 1'b0;

			if (state == TX_IDLE) begin
				if (tx_req && !tx_ack) begin
					tx_ack  <= 1'b1;
					shreg   <= tx_data;
					bit_ctr <= clkdiv;
					uart_tx <= 1'b0;
					state   <= TX_START;
				end
			end else if (bit_ctr != '0) begin
				bit_ctr <= bit_ctr - 1'b1;
			end else begin
				// ------------------------------
				// end of a bit period
				// ------------------------------
				bit_ctr <= clkdiv;
				case (state)
					TX_START: begin
						uart_tx <= shreg[0];
						shreg   <= shreg >> 1;
						bit_idx <= '0;
						state   <= TX_DATA;
					end
					TX_DATA: begin
						if (bit_idx == 3'd7) begin
							uart_tx <= 1'b1;
							state   <= TX_STOP;
						end else begin
							uart_tx <= shreg[0];
							shreg   <= shreg >> 1;
							bit_idx <= bit_idx + 1'b1;
						end
					end
					default: state <= TX_IDLE;
				endcase
			end
		end
	end

endmodule

// ==== design/uart_fifo.sv ====
// UART transmit FIFO: byte ring buffer offering its head by four-phase req/ack
`timescale 1ns/1ps

module uart_fifo (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              push,
	input  periph_pkg::byte_t push_data,
	output logic              full,
	output logic              empty,
	output logic              tx_req,
	output periph_pkg::byte_t tx_data,
	input  logic              tx_ack
);
	import periph_pkg::*;

	byte_t                 mem [UART_FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  pop;

	assign full  = (count == FIFO_CNT_W'(UART_FIFO_DEPTH));
	assign empty = (count == '0);

	// first ack cycle still sees req high
	assign pop     = tx_req && tx_ack;
	assign tx_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			tx_req <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + FIFO_CNT_W'(push) - FIFO_CNT_W'(pop);
			// ------------------------------
			// four-phase handshake
			// ------------------------------
			if (pop)
				tx_req <= 1'b0;
			else if (!tx_req && !tx_ack && !empty)
				tx_req <= 1'b1;
		end
	end

endmodule

// ==== design/uart_regs.sv ====
// UART register block: TXDATA pushes, STATUS, CLKDIV, CTRL and the interrupt
`timescale 1ns/1ps

module uart_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  periph_pkg::apb_addr_t paddr,
	input  periph_pkg::word_t     pwdata,
	output periph_pkg::word_t     prdata,
	output logic                  pslverr,
	output logic                  push,
	output periph_pkg::byte_t     push_data,
	input  logic                  full,
	input  logic                  empty,
	input  logic                  busy,
	output periph_pkg::clkdiv_t   clkdiv,
	output logic                  uart_irq
);
	import periph_pkg::*;

	apb_addr_t offs;
	logic      wr_en;
	logic      txdata_wr;
	logic      irq_en;

	assign offs      = {2'b00, paddr[13:0]};
	assign wr_en     = psel && penable && pwrite;
	assign txdata_wr = wr_en && (offs == UART_TXDATA);

	// ------------------------------
	// transmit path
	// ------------------------------
	// a full fifo drops the byte and errors the access
	assign push      = txdata_wr && !full;
	assign push_data = pwdata[7:0];
	assign pslverr   = txdata_wr && full;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clkdiv <= CLKDIV_RESET;
			irq_en <= 1'b0;
		end else begin
			if (wr_en && offs == UART_CLKDIV)
				clkdiv <= pwdata[15:0];
			if (wr_en && offs == UART_CTRL)
				irq_en <= pwdata[0];
		end
	end

	// TXDATA is write only and reads back as zero
	always_comb begin
		case (offs)
			UART_STATUS: prdata = {29'd0, busy, empty, full};
			UART_CLKDIV: prdata = {16'd0, clkdiv};
			UART_CTRL:   prdata = {31'd0, irq_en};
			default:     prdata = '0;
		endcase
	end

	// everything sent and the line has gone idle
	assign uart_irq = irq_en && empty && !busy;

endmodule

// ==== design/riscv_timer.sv ====
// RISC-V machine timer: microsecond prescaler, 64-bit mtime/mtimecmp and interrupt
`timescale 1ns/1ps

module riscv_timer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  periph_pkg::apb_addr_t paddr,
	input  periph_pkg::word_t     pwdata,
	output periph_pkg::word_t     prdata,
	output logic                  pslverr,
	input  logic                  dbg_halt,
	output logic                  timer_irq
);
	import periph_pkg::*;

	logic [TICK_W-1:0] tick_ctr;
	logic              tick;
	logic              enable;
	logic [63:0]       mtime;
	logic [63:0]       mtimecmp;
	apb_addr_t         offs;
	logic              wr_en;

	// offset within the slave without the region bits
	assign offs  = {2'b00, paddr[13:0]};
	assign wr_en = psel && penable && pwrite;

	// ------------------------------
	// microsecond timebase
	// ------------------------------
	assign tick = (tick_ctr == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= TICK_W'(CLK_MHZ - 1);
		end else if (tick) begin
			tick_ctr <= TICK_W'(CLK_MHZ - 1);
		end else begin
			tick_ctr <= tick_ctr - 1'b1;
		end
	end

	// ------------------------------
	// registers
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable   <= 1'b0;
			mtime    <= '0;
			mtimecmp <= '1;
		end else begin
			if (wr_en && offs == TIMER_CTRL)
				enable <= pwdata[0];
			// a bus write to a half wins over the count
			if (wr_en && offs == TIMER_MTIME)
				mtime[31:0] <= pwdata;
			else if (wr_en && offs == TIMER_MTIMEH)
				mtime[63:32] <= pwdata;
			else if (tick && enable && !dbg_halt)
				mtime <= mtime + 64'd1;
			if (wr_en && offs == TIMER_MTIMECMP)
				mtimecmp[31:0] <= pwdata;
			if (wr_en && offs == TIMER_MTIMECMPH)
				mtimecmp[63:32] <= pwdata;
		end
	end

	always_comb begin
		case (offs)
			TIMER_CTRL:      prdata = {31'd0, enable};
			TIMER_MTIME:     prdata = mtime[31:0];
			TIMER_MTIMEH:    prdata = mtime[63:32];
			TIMER_MTIMECMP:  prdata = mtimecmp[31:0];
			TIMER_MTIMECMPH: prdata = mtimecmp[63:32];
			default:         prdata = '0;
		endcase
	end

	assign pslverr   = 1'b0;
	assign timer_irq = (mtime >= mtimecmp);

endmodule

// ==== design/apb_splitter.sv ====
// APB address splitter: region decode, slave selects and read data/error mux
`timescale 1ns/1ps

module apb_splitter (
	input  logic                 psel,
	input  periph_pkg::apb_addr_t paddr,
	output logic                 timer_psel,
	output logic                 uart_psel,
	input  periph_pkg::word_t    timer_prdata,
	input  logic                 timer_pslverr,
	input  periph_pkg::word_t    uart_prdata,
	input  logic                 uart_pslverr,
	output periph_pkg::word_t    prdata,
	output logic                 pslverr
);
	import periph_pkg::*;

	logic [1:0] region;

	// top two address bits pick the slave
	assign region = paddr[15:14];

	assign timer_psel = psel && (region == REGION_TIMER);
	assign uart_psel  = psel && (region == REGION_UART);

	// ------------------------------
	// response mux
	// ------------------------------
	always_comb begin
		case (region)
			REGION_TIMER: begin
				prdata  = timer_prdata;
				pslverr = timer_pslverr;
			end
			REGION_UART: begin
				prdata  = uart_prdata;
				pslverr = uart_pslverr;
			end
			default: begin
				// nothing lives here, so flag the access
				prdata  = '0;
				pslverr = psel;
			end
		endcase
	end

endmodule

// ==== design/periph_pkg.sv ====
// peripheral subsystem package: bus widths, register map and FSM states
package periph_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	typedef logic [15:0] apb_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] clkdiv_t;

	// clocks per microsecond tick
	localparam int CLK_MHZ         = 4;
	localparam int TICK_W          = $clog2(CLK_MHZ);

	localparam int UART_FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W      = $clog2(UART_FIFO_DEPTH);
	localparam int FIFO_CNT_W      = $clog2(UART_FIFO_DEPTH + 1);

	// decoded from paddr[15:14]
	localparam logic [1:0] REGION_TIMER = 2'd0;
	localparam logic [1:0] REGION_UART  = 2'd1;

	// ------------------------------
	// timer registers
	// ------------------------------
	localparam apb_addr_t TIMER_CTRL      = 16'h0000;
	localparam apb_addr_t TIMER_MTIME     = 16'h0008;
	localparam apb_addr_t TIMER_MTIMEH    = 16'h000c;
	localparam apb_addr_t TIMER_MTIMECMP  = 16'h0010;
	localparam apb_addr_t TIMER_MTIMECMPH = 16'h0014;

	// ------------------------------
	// uart registers
	// ------------------------------
	localparam apb_addr_t UART_TXDATA = 16'h0000;
	localparam apb_addr_t UART_STATUS = 16'h0004;
	localparam apb_addr_t UART_CLKDIV = 16'h0008;
	localparam apb_addr_t UART_CTRL   = 16'h000c;

	localparam clkdiv_t CLKDIV_RESET = 16'd15;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage
